//--- flist.f
+incdir+hdl
hdl/exe_pkg.sv
hdl/exe_dispatch.sv
hdl/mad_unit.sv
hdl/div_unit.sv
hdl/srl_unit.sv
hdl/wb_arbiter.sv
hdl/exe_lane.sv
dv/exe_checker.sv
dv/tb_exe.sv

//--- Bender.yml
package:
  name: exe_lane

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exe_pkg.sv
      - hdl/exe_dispatch.sv
      - hdl/mad_unit.sv
      - hdl/div_unit.sv
      - hdl/srl_unit.sv
      - hdl/wb_arbiter.sv
      - hdl/exe_lane.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/exe_checker.sv
      - dv/tb_exe.sv

//--- dv/tb_exe.sv
// Lane testbench: clock, reset, stimulus table, expected results and watchdog
`default_nettype none

`include "exe_cfg.svh"

module tb_exe;

	localparam int PERIOD	= 100;
	localparam int RST_CYC	= 16;
	localparam int DRV		= 5;		// Drive delay after the rising edge
	localparam int HOLD_CYC	= 48;
	localparam int N_RAND	= 40;
	localparam int MAX_ROWS	= 80;
	localparam int W		= `EXE_DATA_W;

	typedef struct packed {
		exe_pkg::exe_op_e	op;
		logic [W-1:0]		a;
		logic [W-1:0]		b;
		logic [W-1:0]		c;
		logic				hold;		// Part of the hold window
	} row_t;

	logic						clock = 1'b0;
	logic						rst;
	logic						req;
	exe_pkg::exe_cmd_t			cmd;
	logic [`EXE_ISSUE_W-1:0]	cur_issue_no;
	logic						wb_hold;
	logic						stall;
	logic						wb_valid;
	exe_pkg::exe_token_t		wb_token;
	logic [W-1:0]				wb_data;

	logic						exp_push;
	exe_pkg::exe_res_t			exp_res;
	logic [31:0]				exp_seq;
	logic						exp_hold;
	logic						final_check;
	int							n_pend, n_mismatch, n_proto;

	row_t						tbl [MAX_ROWS];
	int							n_rows = 0;
	logic						table_ready = 1'b0;
	int							seed = 32'h77b4;
	logic [31:0]				seq;		// Issue counter
	int							hold_left;

	always #(PERIOD/2) clock = ~clock;

	exe_lane dut0 (
		.clock(clock), .rst(rst), .req(req), .cmd(cmd), .cur_issue_no(cur_issue_no),
		.wb_hold(wb_hold), .stall(stall), .wb_valid(wb_valid), .wb_token(wb_token),
		.wb_data(wb_data)
	);

	exe_checker chk0 (
		.clock(clock), .rst(rst), .stall(stall), .wb_hold(wb_hold), .wb_valid(wb_valid),
		.wb_token(wb_token), .wb_data(wb_data), .exp_push(exp_push), .exp_res(exp_res),
		.exp_seq(exp_seq), .exp_hold(exp_hold), .final_check(final_check),
		.n_pend(n_pend), .n_mismatch(n_mismatch), .n_proto(n_proto)
	);

	function automatic logic [W-1:0] expected_result(row_t r);
		logic [4:0] sh;
		sh = r.b[4:0];
		case (r.op)
			exe_pkg::ADD:	return r.a + r.b;
			exe_pkg::SUB:	return r.a - r.b;
			exe_pkg::MUL:	return r.a * r.b;
			exe_pkg::MAD:	return r.a * r.b + r.c;
			exe_pkg::DIVU:	return (r.b == '0) ? '1 : r.a / r.b;
			exe_pkg::REMU:	return (r.b == '0) ? r.a : r.a % r.b;
			exe_pkg::SLL:	return r.a << sh;
			exe_pkg::SRL:	return r.a >> sh;
			exe_pkg::SRA:	return $signed(r.a) >>> sh;
			exe_pkg::AND:	return r.a & r.b;
			exe_pkg::OR:	return r.a | r.b;
			default:		return r.a ^ r.b;
		endcase
	endfunction

	task automatic add_row(exe_pkg::exe_op_e op, logic [W-1:0] a, logic [W-1:0] b,
			logic [W-1:0] c, logic hold);
		tbl[n_rows] = '{op, a, b, c, hold};
		n_rows++;
	endtask

	task automatic build_table();
		row_t r;
		// Wrap-around arithmetic
		add_row(exe_pkg::ADD, 32'hffff_ffff, 32'h1, 0, 0);
		add_row(exe_pkg::SUB, 32'h0, 32'h1, 0, 0);
		add_row(exe_pkg::MUL, 32'h8000_0000, 32'h2, 0, 0);
		add_row(exe_pkg::MUL, 32'hffff_ffff, 32'hffff_ffff, 0, 0);
		add_row(exe_pkg::MAD, 32'h0001_0000, 32'h0001_0000, 32'h5, 0);
		// Divide by zero and divisor above dividend
		add_row(exe_pkg::DIVU, 32'd100, 32'd0, 0, 0);
		add_row(exe_pkg::REMU, 32'd100, 32'd0, 0, 0);
		add_row(exe_pkg::DIVU, 32'd7, 32'd9, 0, 0);
		add_row(exe_pkg::REMU, 32'd7, 32'd9, 0, 0);
		add_row(exe_pkg::DIVU, 32'hffff_ffff, 32'd3, 0, 0);
		// Shift amounts 0 and 31, sign fill
		add_row(exe_pkg::SLL, 32'h1234_5678, 32'd0, 0, 0);
		add_row(exe_pkg::SLL, 32'h1, 32'd31, 0, 0);
		add_row(exe_pkg::SRL, 32'h8000_0000, 32'd31, 0, 0);
		add_row(exe_pkg::SRA, 32'h8000_0000, 32'd31, 0, 0);
		add_row(exe_pkg::SRA, 32'hffff_fff8, 32'd34, 0, 0);	// Only low five bits count
		add_row(exe_pkg::AND, 32'hf0f0_f0f0, 32'hff00_ff00, 0, 0);
		add_row(exe_pkg::OR, 32'hf0f0_f0f0, 32'h0f0f_0000, 0, 0);
		add_row(exe_pkg::XOR, 32'haaaa_aaaa, 32'hffff_0000, 0, 0);
		// Hold window over all three units
		add_row(exe_pkg::MAD, 32'd3, 32'd5, 32'd7, 1);
		add_row(exe_pkg::SUB, 32'd10, 32'd20, 0, 1);
		add_row(exe_pkg::REMU, 32'd1000, 32'd7, 0, 1);
		add_row(exe_pkg::SLL, 32'h3, 32'd4, 0, 1);
		add_row(exe_pkg::XOR, 32'h5555_5555, 32'h0f0f_0f0f, 0, 1);
		for (int i = 0; i < N_RAND; i++) begin
			r.op	= exe_pkg::exe_op_e'(4'($unsigned($random(seed)) % 12));
			r.a		= $random(seed);
			r.b		= $random(seed);
			r.c		= $random(seed);
			add_row(r.op, r.a, r.b, r.c, 0);
		end
	endtask

	// Advance one cycle and drive the per-cycle inputs
	task automatic next_cycle();
		@(posedge clock);
		#DRV;
		req				= 1'b0;
		exp_push		= 1'b0;
		final_check		= 1'b0;
		cur_issue_no	= seq[`EXE_ISSUE_W-1:0];
		wb_hold			= (hold_left > 0);
		if (hold_left > 0)
			hold_left--;
		#DRV;
	endtask

	task automatic issue_row(row_t r);
		cmd.op					= r.op;
		cmd.dst					= 5'(seq * 7);
		cmd.issue_no			= seq[`EXE_ISSUE_W-1:0];
		cmd.src1				= r.a;
		cmd.src2				= r.b;
		cmd.src3				= r.c;
		req						= 1'b1;
		exp_res.token.v			= 1'b1;
		exp_res.token.op		= r.op;
		exp_res.token.dst		= cmd.dst;
		exp_res.token.issue_no	= cmd.issue_no;
		exp_res.data			= expected_result(r);
		exp_seq					= seq;
		exp_hold				= r.hold;
		exp_push				= 1'b1;
		seq++;
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////
	initial begin
		wait (table_ready);
		#((RST_CYC + n_rows * 40) * PERIOD);
		$display("%0t: watchdog expired with %0d write-backs outstanding", $time, n_pend);
		$display("sim failed");
		$finish;
	end

	initial begin
		int		idx;
		int		drain;
		logic	hold_started;
		rst = 1'b1;
		req = 1'b0;
		cmd = '0;
		cur_issue_no = '0;
		wb_hold = 1'b0;
		exp_push = 1'b0;
		exp_res = '0;
		exp_seq = '0;
		exp_hold = 1'b0;
		final_check = 1'b0;
		seq = '0;
		hold_left = 0;
		hold_started = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (RST_CYC) @(posedge clock);
		#DRV rst = 1'b0;
		idx = 0;
		while (idx < n_rows) begin
			next_cycle();
			if (tbl[idx].hold && !hold_started) begin
				while (n_pend != 0)		// Lane empty before the hold starts
					next_cycle();
				hold_left		= HOLD_CYC;
				hold_started	= 1'b1;
				next_cycle();
			end
			if (!stall) begin
				issue_row(tbl[idx]);
				idx++;
			end
		end
		next_cycle();
		drain = 0;
		while (n_pend != 0 && drain < 200) begin
			next_cycle();
			drain++;
		end
		final_check = 1'b1;
		next_cycle();
		$display("errors: %0d mismatch, %0d other, %0d commands issued",
			n_mismatch, n_proto, seq);
		if (n_mismatch == 0 && n_proto == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/exe_checker.sv
// Write-back checker: matches lane write-backs against expected results by issue number
`default_nettype none

`include "exe_cfg.svh"

module exe_checker (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic						stall,
	input  wire logic						wb_hold,
	input  wire logic						wb_valid,
	input  wire exe_pkg::exe_token_t		wb_token,
	input  wire logic [`EXE_DATA_W-1:0]		wb_data,
	input  wire logic						exp_push,		// One expected entry per strobe
	input  wire exe_pkg::exe_res_t			exp_res,
	input  wire logic [31:0]				exp_seq,
	input  wire logic						exp_hold,
	input  wire logic						final_check,
	output int								n_pend,
	output int								n_mismatch,
	output int								n_proto
);

	localparam int N = 1 << `EXE_ISSUE_W;

	exe_pkg::exe_res_t	pend_res  [N];
	logic [31:0]		pend_seq  [N];		// Full issue count, never wraps
	logic				pend_hold [N];
	logic				pend_v    [N] = '{default: 1'b0};
	int					pend = 0;
	int					mism = 0;
	int					proto = 0;
	logic				rst_q = 1'b0;
	logic				hold_q = 1'b0;
	logic				hold_seen = 1'b0;
	logic				hold_stall = 1'b0;
	logic				order_v = 1'b0;
	logic [31:0]		order_seq = '0;		// Last write-back of the hold window

	assign n_pend		= pend;
	assign n_mismatch	= mism;
	assign n_proto		= proto;

	task automatic record_expected();
		int k;
		k = exp_res.token.issue_no;
		if (pend_v[k]) begin
			$display("%0t: issue number %0d issued again while still outstanding", $time, k);
			proto++;
		end else begin
			pend++;
		end
		pend_v[k]		= 1'b1;
		pend_res[k]		= exp_res;
		pend_seq[k]		= exp_seq;
		pend_hold[k]	= exp_hold;
	endtask

	task automatic check_writeback();
		int k;
		if ($isunknown(wb_token.issue_no)) begin
			$display("%0t: write-back carries an unknown issue number", $time);
			proto++;
			return;
		end
		k = wb_token.issue_no;
		if (!pend_v[k]) begin
			$display("%0t: write-back for issue number %0d that is unknown or a duplicate",
				$time, k);
			proto++;
			return;
		end
		pend_v[k] = 1'b0;
		pend--;
		if (wb_token.dst !== pend_res[k].token.dst) begin
			$display("mismatch at %0t: wb_token.dst expected %0d got %0d (issue %0d)",
				$time, pend_res[k].token.dst, wb_token.dst, k);
			mism++;
		end
		if (wb_token.op !== pend_res[k].token.op) begin
			$display("mismatch at %0t: wb_token.op expected %h got %h (issue %0d)",
				$time, pend_res[k].token.op, wb_token.op, k);
			mism++;
		end
		if (wb_data !== pend_res[k].data) begin
			$display("mismatch at %0t: wb_data expected %h got %h (issue %0d)",
				$time, pend_res[k].data, wb_data, k);
			mism++;
		end
		// After the hold is released the oldest result must leave first
		if (pend_hold[k]) begin
			if (order_v && pend_seq[k] <= order_seq) begin
				$display("%0t: hold window write-back for issue %0d came after a younger one",
					$time, k);
				proto++;
			end
			order_v		= 1'b1;
			order_seq	= pend_seq[k];
		end
	endtask

	task automatic report_lost();
		for (int k = 0; k < N; k++) begin
			if (pend_v[k]) begin
				$display("%0t: no write-back was seen for issue number %0d", $time, k);
				proto++;
			end
		end
		if (hold_seen && !hold_stall) begin
			$display("%0t: stall never rose while wb_hold was high", $time);
			proto++;
		end
	endtask

	//////////////////////////////
	// Sampling at the rising edge
	//////////////////////////////
	always @(posedge clock) begin
		if (rst) begin
			if (rst_q && (wb_valid !== 1'b0 || stall !== 1'b0)) begin
				$display("%0t: wb_valid or stall is not low in reset", $time);
				proto++;
			end
		end else begin
			if ($isunknown({wb_valid, stall})) begin
				$display("%0t: wb_valid or stall is unknown", $time);
				proto++;
			end
			if (wb_hold) begin
				hold_seen = 1'b1;
				if (stall)
					hold_stall = 1'b1;
			end
			if (hold_q && wb_valid) begin	// Registered, so one cycle late
				$display("%0t: write-back came out while wb_hold was high", $time);
				proto++;
			end
			if (exp_push)
				record_expected();
			if (wb_valid)
				check_writeback();
			if (final_check)
				report_lost();
		end
		rst_q	= rst;
		hold_q	= wb_hold;
	end

endmodule

`default_nettype wire

//--- hdl/exe_lane.sv
// Execution lane top: dispatch, three functional units and write-back arbiter
`default_nettype none

`include "exe_cfg.svh"

module exe_lane (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic						req,
	input  wire exe_pkg::exe_cmd_t			cmd,
	input  wire logic [`EXE_ISSUE_W-1:0]	cur_issue_no,
	input  wire logic						wb_hold,
	output logic							stall,
	output logic							wb_valid,
	output exe_pkg::exe_token_t				wb_token,
	output logic [`EXE_DATA_W-1:0]			wb_data
);

	logic					mad_en, div_en, srl_en;
	logic					mad_ready, div_ready, srl_ready;
	logic					mad_take, div_take, srl_take;
	exe_pkg::exe_token_t	unit_tok;		// Shared by all units
	logic [`EXE_DATA_W-1:0]	src1, src2, src3;
	exe_pkg::exe_res_t		mad_res, div_res, srl_res;

	//////////////////////////////
	// Input side
	//////////////////////////////
	exe_dispatch dispatch0 (
		.clock(clock), .rst(rst), .req(req), .cmd(cmd),
		.mad_ready(mad_ready), .div_ready(div_ready), .srl_ready(srl_ready),
		.mad_en(mad_en), .div_en(div_en), .srl_en(srl_en),
		.unit_tok(unit_tok), .src1(src1), .src2(src2), .src3(src3), .stall(stall)
	);

	mad_unit mad0 (
		.clock(clock), .rst(rst), .en(mad_en), .tok(unit_tok),
		.src1(src1), .src2(src2), .src3(src3),
		.take(mad_take), .ready(mad_ready), .res(mad_res)
	);

	div_unit div0 (
		.clock(clock), .rst(rst), .en(div_en), .tok(unit_tok),
		.src1(src1), .src2(src2),
		.take(div_take), .ready(div_ready), .res(div_res)
	);

	srl_unit srl0 (
		.clock(clock), .rst(rst), .en(srl_en), .tok(unit_tok),
		.src1(src1), .src2(src2),
		.take(srl_take), .ready(srl_ready), .res(srl_res)
	);

	// Output side
	wb_arbiter arb0 (
		.clock(clock), .rst(rst), .cur_issue_no(cur_issue_no), .wb_hold(wb_hold),
		.mad_res(mad_res), .div_res(div_res), .srl_res(srl_res),
		.mad_take(mad_take), .div_take(div_take), .srl_take(srl_take),
		.wb_valid(wb_valid), .wb_token(wb_token), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
// Write-back arbiter: grants the oldest finished result and registers it
`default_nettype none

`include "exe_cfg.svh"

module wb_arbiter (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic [`EXE_ISSUE_W-1:0]	cur_issue_no,
	input  wire logic						wb_hold,
	input  wire exe_pkg::exe_res_t			mad_res,
	input  wire exe_pkg::exe_res_t			div_res,
	input  wire exe_pkg::exe_res_t			srl_res,
	output logic							mad_take,
	output logic							div_take,
	output logic							srl_take,
	output logic							wb_valid,
	output exe_pkg::exe_token_t				wb_token,
	output logic [`EXE_DATA_W-1:0]			wb_data
);

	logic [`EXE_ISSUE_W-1:0]	age_mad;
	logic [`EXE_ISSUE_W-1:0]	age_div;
	logic [`EXE_ISSUE_W-1:0]	age_srl;
	logic [`EXE_ISSUE_W-1:0]	best_age;
	exe_pkg::exe_unit_e			sel;
	exe_pkg::exe_res_t			pick;
	logic						any;
	logic						grant;

	// Age wraps modulo the issue-number width
	assign age_mad = cur_issue_no - mad_res.token.issue_no;
	assign age_div = cur_issue_no - div_res.token.issue_no;
	assign age_srl = cur_issue_no - srl_res.token.issue_no;

	//////////////////////////////
	// Oldest first, ties MAD > DIV > SRL
	//////////////////////////////
	always_comb begin
		any			= 1'b0;
		sel			= exe_pkg::UNIT_MAD;
		best_age	= '0;
		if (mad_res.token.v) begin
			any			= 1'b1;
			best_age	= age_mad;
		end
		if (div_res.token.v && (!any || age_div > best_age)) begin
			any			= 1'b1;
			sel			= exe_pkg::UNIT_DIV;
			best_age	= age_div;
		end
		if (srl_res.token.v && (!any || age_srl > best_age)) begin
			any			= 1'b1;
			sel			= exe_pkg::UNIT_SRL;
		end
	end

	always_comb begin
		case (sel)
			exe_pkg::UNIT_DIV:	pick = div_res;
			exe_pkg::UNIT_SRL:	pick = srl_res;
			default:			pick = mad_res;
		endcase
	end

	assign grant	= any & ~wb_hold;		// Hold blocks every take
	assign mad_take	= grant & (sel == exe_pkg::UNIT_MAD);
	assign div_take	= grant & (sel == exe_pkg::UNIT_DIV);
	assign srl_take	= grant & (sel == exe_pkg::UNIT_SRL);

	always_ff @(posedge clock) begin
		if (rst) begin
			wb_token.v <= 1'b0;
		end else if (grant) begin
			wb_token	<= pick.token;
			wb_data		<= pick.data;
		end else begin
			wb_token.v	<= 1'b0;
		end
	end

	assign wb_valid = wb_token.v;

	// A finished result that is not taken must stay frozen
	a_mad_frozen: assert property (@(posedge clock) disable iff (rst)
		mad_res.token.v && !mad_take |=> $stable(mad_res))
		else $error("MAD result changed while not taken");

	a_div_frozen: assert property (@(posedge clock) disable iff (rst)
		div_res.token.v && !div_take |=> $stable(div_res))
		else $error("DIV result changed while not taken");

	a_srl_frozen: assert property (@(posedge clock) disable iff (rst)
		srl_res.token.v && !srl_take |=> $stable(srl_res))
		else $error("SRL result changed while not taken");

endmodule

`default_nettype wire

//--- hdl/srl_unit.sv
// Shift/logic unit: one registered stage of shifts and bitwise ops
`default_nettype none

`include "exe_cfg.svh"

module srl_unit (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic						en,
	input  wire exe_pkg::exe_token_t		tok,
	input  wire logic [`EXE_DATA_W-1:0]		src1,
	input  wire logic [`EXE_DATA_W-1:0]		src2,
	input  wire logic						take,
	output logic							ready,
	output exe_pkg::exe_res_t				res
);

	logic [4:0]				sh;
	logic [`EXE_DATA_W-1:0]	val;
	logic					adv;

	assign sh		= src2[4:0];				// Low five bits only
	assign adv		= ~res.token.v | take;
	assign ready	= adv;

	always_comb begin
		case (tok.op)
			exe_pkg::SLL:	val = src1 << sh;
			exe_pkg::SRL:	val = src1 >> sh;
			exe_pkg::SRA:	val = $signed(src1) >>> sh;	// Sign fill
			exe_pkg::AND:	val = src1 & src2;
			exe_pkg::OR:	val = src1 | src2;
			exe_pkg::XOR:	val = src1 ^ src2;
			default:		val = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			res.token.v <= 1'b0;
		end else if (adv) begin
			res.token	<= tok;
			res.token.v	<= en;
			res.data	<= val;
		end
	end

endmodule

`default_nettype wire

//--- hdl/div_unit.sv
// Divider: iterative restoring unsigned divide giving quotient or remainder
`default_nettype none

`include "exe_cfg.svh"

module div_unit (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic						en,
	input  wire exe_pkg::exe_token_t		tok,
	input  wire logic [`EXE_DATA_W-1:0]		src1,
	input  wire logic [`EXE_DATA_W-1:0]		src2,
	input  wire logic						take,
	output logic							ready,
	output exe_pkg::exe_res_t				res
);

	localparam int W	= `EXE_DATA_W;
	localparam int CW	= $clog2(`EXE_DATA_W);

	exe_pkg::div_state_e	state;
	exe_pkg::exe_token_t	tok_q;
	logic [CW-1:0]			cnt;		// Iteration count
	logic [W-1:0]			quo;		// Dividend shifts out, quotient shifts in
	logic [W-1:0]			rem;
	logic [W-1:0]			dvs;
	logic [W:0]				rem_sh;
	logic [W:0]				trial;

	assign ready = (state == exe_pkg::IDLE);

	//////////////////////////////
	// Control
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= exe_pkg::IDLE;
		end else begin
			case (state)
				exe_pkg::IDLE:	if (en) state <= exe_pkg::RUN;
				exe_pkg::RUN:	if (cnt == CW'(W-1)) state <= exe_pkg::DONE;
				exe_pkg::DONE:	if (take) state <= exe_pkg::IDLE;	// Held until taken
				default:		state <= exe_pkg::IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	// Divisor zero never borrows, so quotient ends all ones and remainder keeps dividend
	assign rem_sh	= {rem, quo[W-1]};
	assign trial	= rem_sh - {1'b0, dvs};

	always_ff @(posedge clock) begin
		if (state == exe_pkg::IDLE && en) begin
			quo		<= src1;
			rem		<= '0;
			dvs		<= src2;
			cnt		<= '0;
			tok_q	<= tok;
		end else if (state == exe_pkg::RUN) begin
			quo		<= {quo[W-2:0], ~trial[W]};
			rem		<= trial[W] ? rem_sh[W-1:0] : trial[W-1:0];	// Restore on borrow
			cnt		<= cnt + 1'b1;
		end
	end

	always_comb begin
		res.token	= tok_q;
		res.token.v	= (state == exe_pkg::DONE);
		res.data	= (tok_q.op == exe_pkg::REMU) ? rem : quo;
	end

	a_en_idle: assert property (@(posedge clock) disable iff (rst)
		en |-> state == exe_pkg::IDLE)
		else $error("divider enabled while busy");

endmodule

`default_nettype wire

//--- hdl/mad_unit.sv
// Multiply-add unit: pipelined add, subtract, multiply and multiply-add with freeze
`default_nettype none

`include "exe_cfg.svh"

module mad_unit (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic						en,
	input  wire exe_pkg::exe_token_t		tok,
	input  wire logic [`EXE_DATA_W-1:0]		src1,
	input  wire logic [`EXE_DATA_W-1:0]		src2,
	input  wire logic [`EXE_DATA_W-1:0]		src3,
	input  wire logic						take,
	output logic							ready,
	output exe_pkg::exe_res_t				res
);

	localparam int W = `EXE_DATA_W;
	localparam int D = `EXE_MAD_DEPTH;

	// Stage payload ahead of the final add
	typedef struct packed {
		exe_pkg::exe_token_t	tok;
		logic [W-1:0]			a;		// Product or src1
		logic [W-1:0]			b;		// Addend or subtrahend
	} stage_t;

	stage_t			head;
	stage_t			pipe [D-1];
	logic [W-1:0]	sum;
	logic			adv;

	// Whole pipe moves only when the result slot frees up
	assign adv		= ~res.token.v | take;
	assign ready	= adv;

	//////////////////////////////
	// Stage one: multiply
	//////////////////////////////
	always_comb begin
		head		= '0;
		head.tok	= tok;
		head.tok.v	= en;
		if (tok.op == exe_pkg::MUL || tok.op == exe_pkg::MAD)
			head.a = src1 * src2;		// Low half of the product
		else
			head.a = src1;
		if (tok.op == exe_pkg::MAD)
			head.b = src3;
		else if (tok.op == exe_pkg::SUB || tok.op == exe_pkg::ADD)
			head.b = src2;
	end

	// Last stage adds or subtracts
	assign sum = (pipe[D-2].tok.op == exe_pkg::SUB) ? pipe[D-2].a - pipe[D-2].b
	                                                 : pipe[D-2].a + pipe[D-2].b;

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < D-1; i++)
				pipe[i].tok.v <= 1'b0;
			res.token.v <= 1'b0;
		end else if (adv) begin
			pipe[0] <= head;
			for (int i = 1; i < D-1; i++)
				pipe[i] <= pipe[i-1];
			res.token	<= pipe[D-2].tok;
			res.data	<= sum;
		end
	end

endmodule

`default_nettype wire

//--- hdl/exe_dispatch.sv
// Dispatch: decodes the opcode, enables one unit and drives the issue stall
`default_nettype none

`include "exe_cfg.svh"

module exe_dispatch (
	input  wire logic						clock,
	input  wire logic						rst,
	input  wire logic						req,
	input  wire exe_pkg::exe_cmd_t			cmd,
	input  wire logic						mad_ready,
	input  wire logic						div_ready,
	input  wire logic						srl_ready,
	output logic							mad_en,
	output logic							div_en,
	output logic							srl_en,
	output exe_pkg::exe_token_t				unit_tok,
	output logic [`EXE_DATA_W-1:0]			src1,
	output logic [`EXE_DATA_W-1:0]			src2,
	output logic [`EXE_DATA_W-1:0]			src3,
	output logic							stall
);

	exe_pkg::exe_unit_e		unit;
	logic					op_ok;		// Opcode is a known encoding
	logic					accept;
	logic					go;

	// Stall depends on unit readiness only, never on req
	assign stall	= ~(mad_ready & div_ready & srl_ready);
	assign accept	= req & ~stall;
	assign go		= accept & op_ok;

	always_comb begin
		unit	= exe_pkg::UNIT_SRL;
		op_ok	= 1'b1;
		case (cmd.op)
			exe_pkg::ADD, exe_pkg::SUB, exe_pkg::MUL, exe_pkg::MAD:		unit = exe_pkg::UNIT_MAD;
			exe_pkg::DIVU, exe_pkg::REMU:								unit = exe_pkg::UNIT_DIV;
			exe_pkg::SLL, exe_pkg::SRL, exe_pkg::SRA,
			exe_pkg::AND, exe_pkg::OR, exe_pkg::XOR:					unit = exe_pkg::UNIT_SRL;
			default:													op_ok = 1'b0;
		endcase
	end

	assign mad_en	= go & (unit == exe_pkg::UNIT_MAD);
	assign div_en	= go & (unit == exe_pkg::UNIT_DIV);
	assign srl_en	= go & (unit == exe_pkg::UNIT_SRL);

	// Token and operands are zero unless a command goes out
	always_comb begin
		unit_tok = '0;
		if (go) begin
			unit_tok.v			= 1'b1;
			unit_tok.op			= cmd.op;
			unit_tok.dst		= cmd.dst;
			unit_tok.issue_no	= cmd.issue_no;
		end
	end

	assign src1	= go ? cmd.src1 : '0;
	assign src2	= go ? cmd.src2 : '0;
	assign src3	= (go && cmd.op == exe_pkg::MAD) ? cmd.src3 : '0;	// Addend for MAD only

	a_req_while_stall: assert property (@(posedge clock) disable iff (rst) req |-> !stall)
		else $error("req raised while stall is high");

	a_en_onehot: assert property (@(posedge clock) disable iff (rst)
		accept |-> $onehot({mad_en, div_en, srl_en}))
		else $error("accepted command did not enable exactly one unit");

endmodule

`default_nettype wire

//--- hdl/exe_pkg.sv
// Execution lane types: opcodes, unit select, command, token and result structs
`default_nettype none

`include "exe_cfg.svh"

package exe_pkg;

	// Integer opcodes handled by the lane
	typedef enum logic [3:0] {
		ADD		= 4'h0,
		SUB		= 4'h1,
		MUL		= 4'h2,
		MAD		= 4'h3,		// src1 * src2 + src3
		DIVU	= 4'h4,
		REMU	= 4'h5,
		SLL		= 4'h6,
		SRL		= 4'h7,
		SRA		= 4'h8,
		AND		= 4'h9,
		OR		= 4'hA,
		XOR		= 4'hB
	} exe_op_e;

	// Functional unit that executes an opcode
	typedef enum logic [1:0] {
		UNIT_MAD	= 2'd0,
		UNIT_DIV	= 2'd1,
		UNIT_SRL	= 2'd2
	} exe_unit_e;

	// Divider sequencing
	typedef enum logic [1:0] {
		IDLE	= 2'd0,
		RUN		= 2'd1,
		DONE	= 2'd2
	} div_state_e;

	//////////////////////////////
	// Command and write-back
	//////////////////////////////

	typedef struct packed {
		exe_op_e					op;
		logic [`EXE_DST_W-1:0]		dst;
		logic [`EXE_ISSUE_W-1:0]	issue_no;
		logic [`EXE_DATA_W-1:0]		src1;
		logic [`EXE_DATA_W-1:0]		src2;
		logic [`EXE_DATA_W-1:0]		src3;
	} exe_cmd_t;

	typedef struct packed {
		logic						v;			// Result finished
		exe_op_e					op;
		logic [`EXE_DST_W-1:0]		dst;
		logic [`EXE_ISSUE_W-1:0]	issue_no;
	} exe_token_t;

	typedef struct packed {
		exe_token_t					token;
		logic [`EXE_DATA_W-1:0]		data;
	} exe_res_t;

endpackage

`default_nettype wire

//--- hdl/exe_cfg.svh
// Execution lane configuration: data, issue, destination widths and MAD depth
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Operand and result width
`define EXE_DATA_W		32

// Issue number width; age arithmetic wraps at this width
`define EXE_ISSUE_W		6

// Destination register index
`define EXE_DST_W		5

//////////////////////////////
// Units
//////////////////////////////

// Register stages in the multiply-add pipe, at least 2
`define EXE_MAD_DEPTH	3

`endif
